//--- logic/fifo19_to_ll8.sv
`default_nettype none

module fifo19_to_ll8 (
   input  logic                 clk125,
   input  logic                 reset_i,
   input  gemac_pkg::f19_word_t f19_data_i,
   input  logic                 f19_valid_i,
   output logic                 f19_ready_o,
   output gemac_pkg::byte_t     ll_data_o,
   output logic                 ll_sof_o,
   output logic                 ll_eof_o,
   output logic                 ll_valid_o,
   input  logic                 ll_ready_i
);

   import gemac_pkg::*;

   f19_word_t word_q;
   logic      second_q;
   logic      last;

   // A half word ends on its first byte
   assign last = second_q || (word_q[F19_EOF_BIT] && word_q[F19_HALF_BIT]);

   // Next word is taken while the last byte of this one leaves
   assign f19_ready_o = !reset_i && (!ll_valid_o || (ll_ready_i && last));

   assign ll_data_o = second_q ? word_q[7:0] : word_q[15:8];
   assign ll_sof_o  = word_q[F19_SOF_BIT] && !second_q;
   assign ll_eof_o  = word_q[F19_EOF_BIT] && last;

   always_ff @(posedge clk125) begin
      if (reset_i) begin
         ll_valid_o <= 1'b0;
         second_q   <= 1'b0;
      end else if (f19_valid_i && f19_ready_o) begin
         ll_valid_o <= 1'b1;
         second_q   <= 1'b0;
      end else if (ll_valid_o && ll_ready_i) begin
         if (last) begin
            ll_valid_o <= 1'b0;
         end else begin
            second_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk125) begin
      if (f19_valid_i && f19_ready_o) begin
         word_q <= f19_data_i;
      end
   end

endmodule

`default_nettype wire

//--- logic/flow_ctrl_rx.sv
`default_nettype none

module flow_ctrl_rx (
   input  logic                   clk125,
   input  logic                   reset_i,
   input  gemac_pkg::fifo_space_t space_i,
   input  logic                   pause_request_en_i,
   input  gemac_pkg::pause_time_t pause_time_i,
   input  gemac_pkg::fifo_space_t pause_thresh_i,
   output logic                   pause_req_o,
   output gemac_pkg::pause_time_t pause_time_req_o
);

   import gemac_pkg::*;

   logic [PAUSE_QUANTUM_W-1:0] qcnt_q;
   pause_time_t                quanta_left_q;
   logic                       paused_q;
   logic                       space_low;
   logic                       q_wrap;
   logic                       repeat_due;

   assign space_low  = (space_i < pause_thresh_i);
   assign q_wrap     = (qcnt_q == PAUSE_QUANTUM_W'(PAUSE_QUANTUM_CYCLES - 1));
   // Refresh once half of the requested pause has run out
   assign repeat_due = paused_q && q_wrap && (quanta_left_q <= 16'd1);

   always_ff @(posedge clk125) begin
      if (reset_i) begin
         paused_q         <= 1'b0;
         pause_req_o      <= 1'b0;
         pause_time_req_o <= '0;
         qcnt_q           <= '0;
         quanta_left_q    <= '0;
      end else begin
         pause_req_o <= 1'b0;
         qcnt_q      <= qcnt_q + 1'b1;
         if (pause_request_en_i && space_low && (!paused_q || repeat_due)) begin
            pause_req_o      <= 1'b1;
            pause_time_req_o <= pause_time_i;
            paused_q         <= 1'b1;
            quanta_left_q    <= pause_time_i >> 1;
            qcnt_q           <= '0;
         end else if (paused_q && !space_low) begin
            // Resume with a zero pause time
            pause_req_o      <= 1'b1;
            pause_time_req_o <= '0;
            paused_q         <= 1'b0;
         end else if (q_wrap && quanta_left_q != '0) begin
            quanta_left_q <= quanta_left_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/gemac_client_bridge.sv
`default_nettype none

module gemac_client_bridge (
   input  logic                   clk125,
   input  logic                   reset_i,
   input  gemac_pkg::byte_t       rx_data_i,
   input  logic                   rx_valid_i,
   input  logic                   rx_error_i,
   output gemac_pkg::f19_word_t   rx_f19_data_o,
   output logic                   rx_f19_valid_o,
   input  logic                   rx_f19_ready_i,
   output logic [15:0]            rx_dropped_o,
   input  gemac_pkg::f19_word_t   tx_f19_data_i,
   input  logic                   tx_f19_valid_i,
   output logic                   tx_f19_ready_o,
   output gemac_pkg::byte_t       tx_data_o,
   output logic                   tx_valid_o,
   output logic                   tx_error_o,
   input  logic                   tx_ack_i,
   input  logic                   pause_request_en_i,
   input  gemac_pkg::pause_time_t pause_time_i,
   input  gemac_pkg::fifo_space_t pause_thresh_i,
   output logic                   pause_req_o,
   output gemac_pkg::pause_time_t pause_time_req_o
);

   import gemac_pkg::*;

   byte_t       ll_data;
   logic        ll_sof;
   logic        ll_eof;
   logic        ll_error;
   logic        ll_valid;
   f19_word_t   wr_word;
   logic        wr_error;
   logic        wr_valid;
   fifo_space_t rx_space;
   byte_t       tx_ll_data;
   logic        tx_ll_sof;
   logic        tx_ll_eof;
   logic        tx_ll_valid;
   logic        tx_ll_ready;

   // Receive chain
   rxmac_to_ll8 rx_adapt_i (
      .clk125(clk125), .reset_i(reset_i),
      .rx_data_i(rx_data_i), .rx_valid_i(rx_valid_i), .rx_error_i(rx_error_i),
      .ll_data_o(ll_data), .ll_sof_o(ll_sof), .ll_eof_o(ll_eof),
      .ll_error_o(ll_error), .ll_valid_o(ll_valid));

   ll8_to_fifo19 rx_pack_i (
      .clk125(clk125), .reset_i(reset_i),
      .ll_data_i(ll_data), .ll_sof_i(ll_sof), .ll_eof_i(ll_eof),
      .ll_error_i(ll_error), .ll_valid_i(ll_valid),
      .wr_word_o(wr_word), .wr_error_o(wr_error), .wr_valid_o(wr_valid));

   rx_frame_fifo rx_fifo_i (
      .clk125(clk125), .reset_i(reset_i),
      .wr_word_i(wr_word), .wr_error_i(wr_error), .wr_valid_i(wr_valid),
      .rd_ready_i(rx_f19_ready_i), .rd_word_o(rx_f19_data_o), .rd_valid_o(rx_f19_valid_o),
      .space_o(rx_space), .dropped_o(rx_dropped_o));

   flow_ctrl_rx flow_ctrl_i (
      .clk125(clk125), .reset_i(reset_i), .space_i(rx_space),
      .pause_request_en_i(pause_request_en_i), .pause_time_i(pause_time_i),
      .pause_thresh_i(pause_thresh_i),
      .pause_req_o(pause_req_o), .pause_time_req_o(pause_time_req_o));

   // Transmit chain
   fifo19_to_ll8 tx_unpack_i (
      .clk125(clk125), .reset_i(reset_i),
      .f19_data_i(tx_f19_data_i), .f19_valid_i(tx_f19_valid_i), .f19_ready_o(tx_f19_ready_o),
      .ll_data_o(tx_ll_data), .ll_sof_o(tx_ll_sof), .ll_eof_o(tx_ll_eof),
      .ll_valid_o(tx_ll_valid), .ll_ready_i(tx_ll_ready));

   ll8_to_txmac tx_adapt_i (
      .clk125(clk125), .reset_i(reset_i),
      .ll_data_i(tx_ll_data), .ll_sof_i(tx_ll_sof), .ll_eof_i(tx_ll_eof),
      .ll_valid_i(tx_ll_valid), .ll_ready_o(tx_ll_ready),
      .tx_data_o(tx_data_o), .tx_valid_o(tx_valid_o), .tx_error_o(tx_error_o),
      .tx_ack_i(tx_ack_i));

endmodule

`default_nettype wire

//--- logic/gemac_pkg.sv
`default_nettype none

package gemac_pkg;

   typedef logic [7:0]  byte_t;

   // Bits 15:8 first byte, 7:0 second byte, sof/eof/half flags above
   typedef logic [18:0] f19_word_t;

   typedef logic [15:0] fifo_space_t;

   // Quanta of 512 bit times
   typedef logic [15:0] pause_time_t;

   localparam int F19_SOF_BIT  = 16;
   localparam int F19_EOF_BIT  = 17;
   localparam int F19_HALF_BIT = 18;

   localparam int RX_FIFO_ADDR_W = 6;
   localparam int RX_FIFO_DEPTH  = 1 << RX_FIFO_ADDR_W;

   // One quantum is 64 byte times on a gigabit link
   localparam int PAUSE_QUANTUM_CYCLES = 64;
   localparam int PAUSE_QUANTUM_W      = $clog2(PAUSE_QUANTUM_CYCLES);

endpackage

`default_nettype wire

//--- logic/ll8_to_fifo19.sv
`default_nettype none

module ll8_to_fifo19 (
   input  logic                 clk125,
   input  logic                 reset_i,
   input  gemac_pkg::byte_t     ll_data_i,
   input  logic                 ll_sof_i,
   input  logic                 ll_eof_i,
   input  logic                 ll_error_i,
   input  logic                 ll_valid_i,
   output gemac_pkg::f19_word_t wr_word_o,
   output logic                 wr_error_o,
   output logic                 wr_valid_o
);

   import gemac_pkg::*;

   byte_t     first_q;
   logic      first_sof_q;
   logic      pend_q;
   f19_word_t word_d;

   always_comb begin
      word_d = '0;
      if (pend_q) begin
         word_d[15:8]        = first_q;
         word_d[7:0]         = ll_data_i;
         word_d[F19_SOF_BIT] = first_sof_q;
      end else begin
         // Only sent when this byte ends the frame
         word_d[15:8]         = ll_data_i;
         word_d[F19_SOF_BIT]  = ll_sof_i;
         word_d[F19_HALF_BIT] = 1'b1;
      end
      word_d[F19_EOF_BIT] = ll_eof_i;
   end

   always_ff @(posedge clk125) begin
      if (reset_i) begin
         pend_q     <= 1'b0;
         wr_valid_o <= 1'b0;
         wr_error_o <= 1'b0;
      end else begin
         wr_valid_o <= 1'b0;
         wr_error_o <= 1'b0;
         if (ll_valid_i) begin
            if (pend_q || ll_eof_i) begin
               wr_valid_o <= 1'b1;
               wr_error_o <= ll_error_i & ll_eof_i;
               pend_q     <= 1'b0;
            end else begin
               pend_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk125) begin
      if (ll_valid_i && !pend_q) begin
         first_q     <= ll_data_i;
         first_sof_q <= ll_sof_i;
      end
      if (ll_valid_i) begin
         wr_word_o <= word_d;
      end
   end

endmodule

`default_nettype wire

//--- logic/ll8_to_txmac.sv
`default_nettype none

module ll8_to_txmac (
   input  logic             clk125,
   input  logic             reset_i,
   input  gemac_pkg::byte_t ll_data_i,
   input  logic             ll_sof_i,
   input  logic             ll_eof_i,
   input  logic             ll_valid_i,
   output logic             ll_ready_o,
   output gemac_pkg::byte_t tx_data_o,
   output logic             tx_valid_o,
   output logic             tx_error_o,
   input  logic             tx_ack_i
);

   typedef enum logic [2:0] {S_IDLE, S_WAIT_ACK, S_SEND, S_UNDERRUN, S_DROP} state_t;

   state_t state_q;
   logic   last_q;
   logic   take;

   always_comb begin
      case (state_q)
         S_WAIT_ACK: ll_ready_o = tx_ack_i && !last_q;
         S_SEND:     ll_ready_o = !last_q;
         default:    ll_ready_o = 1'b1;
      endcase
   end

   // MAC takes the byte on ack, then one every cycle
   assign take = (state_q == S_SEND) || (state_q == S_WAIT_ACK && tx_ack_i);

   always_ff @(posedge clk125) begin
      if (reset_i) begin
         state_q    <= S_IDLE;
         last_q     <= 1'b0;
         tx_valid_o <= 1'b0;
         tx_error_o <= 1'b0;
      end else begin
         tx_error_o <= 1'b0;
         case (state_q)
            S_IDLE: begin
               // Stray bytes outside a frame are dropped
               if (ll_valid_i && ll_sof_i) begin
                  tx_valid_o <= 1'b1;
                  last_q     <= ll_eof_i;
                  state_q    <= S_WAIT_ACK;
               end
            end
            S_WAIT_ACK, S_SEND: begin
               if (take) begin
                  if (last_q) begin
                     tx_valid_o <= 1'b0;
                     state_q    <= S_IDLE;
                  end else if (ll_valid_i) begin
                     last_q  <= ll_eof_i;
                     state_q <= S_SEND;
                  end else begin
                     // Underrun
                     tx_valid_o <= 1'b0;
                     tx_error_o <= 1'b1;
                     state_q    <= S_UNDERRUN;
                  end
               end
            end
            default: begin
               if (ll_valid_i && ll_eof_i) begin
                  state_q <= S_IDLE;
               end else begin
                  state_q <= S_DROP;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk125) begin
      if (ll_valid_i && ll_ready_o) begin
         tx_data_o <= ll_data_i;
      end
   end

   a_ack_in_wait: assert property (@(posedge clk125) disable iff (reset_i)
      tx_ack_i |-> state_q == S_WAIT_ACK);

endmodule

`default_nettype wire

//--- logic/rx_frame_fifo.sv
`default_nettype none

module rx_frame_fifo (
   input  logic                   clk125,
   input  logic                   reset_i,
   input  gemac_pkg::f19_word_t   wr_word_i,
   input  logic                   wr_error_i,
   input  logic                   wr_valid_i,
   input  logic                   rd_ready_i,
   output gemac_pkg::f19_word_t   rd_word_o,
   output logic                   rd_valid_o,
   output gemac_pkg::fifo_space_t space_o,
   output logic [15:0]            dropped_o
);

   import gemac_pkg::*;

   typedef logic [RX_FIFO_ADDR_W:0] ptr_t;

   f19_word_t mem_q [RX_FIFO_DEPTH];
   ptr_t      wr_ptr_q;
   ptr_t      commit_ptr_q;
   ptr_t      rd_ptr_q;
   ptr_t      used;
   logic      full;
   logic      ovf_q;
   logic      load;

   // Uncommitted words count as used
   assign used    = wr_ptr_q - rd_ptr_q;
   assign full    = (used == ptr_t'(RX_FIFO_DEPTH));
   assign space_o = fifo_space_t'(RX_FIFO_DEPTH) - fifo_space_t'(used);

   always_ff @(posedge clk125) begin
      if (reset_i) begin
         wr_ptr_q     <= '0;
         commit_ptr_q <= '0;
         ovf_q        <= 1'b0;
         dropped_o    <= '0;
      end else if (wr_valid_i) begin
         if (wr_word_i[F19_EOF_BIT]) begin
            if (wr_error_i || ovf_q || full) begin
               // Rewind over the whole frame
               wr_ptr_q  <= commit_ptr_q;
               dropped_o <= dropped_o + 16'd1;
            end else begin
               wr_ptr_q     <= wr_ptr_q + 1'b1;
               commit_ptr_q <= wr_ptr_q + 1'b1;
            end
            ovf_q <= 1'b0;
         end else if (full) begin
            ovf_q <= 1'b1;
         end else if (!ovf_q) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk125) begin
      if (wr_valid_i && !full && !ovf_q) begin
         mem_q[wr_ptr_q[RX_FIFO_ADDR_W-1:0]] <= wr_word_i;
      end
   end

   // Registered fall-through stage over committed words only
   assign load = (rd_ptr_q != commit_ptr_q) && (!rd_valid_o || rd_ready_i);

   always_ff @(posedge clk125) begin
      if (reset_i) begin
         rd_ptr_q   <= '0;
         rd_valid_o <= 1'b0;
      end else if (load) begin
         rd_ptr_q   <= rd_ptr_q + 1'b1;
         rd_valid_o <= 1'b1;
      end else if (rd_ready_i) begin
         rd_valid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk125) begin
      if (load) begin
         rd_word_o <= mem_q[rd_ptr_q[RX_FIFO_ADDR_W-1:0]];
      end
   end

   a_rd_behind_commit: assert property (@(posedge clk125) disable iff (reset_i)
      ptr_t'(commit_ptr_q - rd_ptr_q) <= ptr_t'(RX_FIFO_DEPTH));

   a_space_bound: assert property (@(posedge clk125) disable iff (reset_i)
      space_o <= fifo_space_t'(RX_FIFO_DEPTH));

endmodule

`default_nettype wire

//--- logic/rxmac_to_ll8.sv
`default_nettype none

module rxmac_to_ll8 (
   input  logic             clk125,
   input  logic             reset_i,
   input  gemac_pkg::byte_t rx_data_i,
   input  logic             rx_valid_i,
   input  logic             rx_error_i,
   output gemac_pkg::byte_t ll_data_o,
   output logic             ll_sof_o,
   output logic             ll_eof_o,
   output logic             ll_error_o,
   output logic             ll_valid_o
);

   import gemac_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_FIRST, S_BODY} state_t;

   state_t state_q;
   byte_t  hold_q;
   logic   err_q;

   // One byte is held back so the last one can carry eof
   always_ff @(posedge clk125) begin
      if (reset_i) begin
         state_q    <= S_IDLE;
         err_q      <= 1'b0;
         ll_valid_o <= 1'b0;
         ll_sof_o   <= 1'b0;
         ll_eof_o   <= 1'b0;
         ll_error_o <= 1'b0;
      end else begin
         ll_valid_o <= 1'b0;
         ll_sof_o   <= 1'b0;
         ll_eof_o   <= 1'b0;
         ll_error_o <= 1'b0;
         if (state_q == S_IDLE) begin
            if (rx_valid_i) begin
               state_q <= S_FIRST;
               err_q   <= rx_error_i;
            end
         end else begin
            ll_valid_o <= 1'b1;
            ll_sof_o   <= (state_q == S_FIRST);
            if (rx_valid_i) begin
               err_q   <= err_q | rx_error_i;
               state_q <= S_BODY;
            end else begin
               ll_eof_o   <= 1'b1;
               ll_error_o <= err_q;
               state_q    <= S_IDLE;
            end
         end
      end
   end

   always_ff @(posedge clk125) begin
      if (rx_valid_i) begin
         hold_q <= rx_data_i;
      end
      ll_data_o <= hold_q;
   end

   a_error_on_eof: assert property (@(posedge clk125) disable iff (reset_i)
      ll_error_o |-> ll_eof_o && ll_valid_o);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; pass means the pass message was printed

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_gemac_client_bridge -f sources.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- sources.f
logic/gemac_pkg.sv
logic/rxmac_to_ll8.sv
logic/ll8_to_fifo19.sv
logic/rx_frame_fifo.sv
logic/flow_ctrl_rx.sv
logic/fifo19_to_ll8.sv
logic/ll8_to_txmac.sv
logic/gemac_client_bridge.sv
tb/tb_gemac_client_bridge.sv

//--- tb/tb_gemac_client_bridge.sv
`default_nettype none

module tb_gemac_client_bridge;

   timeunit 1ns;
   timeprecision 1ps;

   import gemac_pkg::*;

   logic        clk125 = 1'b0;
   logic        reset_i;
   byte_t       rx_data_i;
   logic        rx_valid_i;
   logic        rx_error_i;
   logic        rx_f19_ready_i = 1'b0;
   f19_word_t   tx_f19_data_i;
   logic        tx_f19_valid_i;
   logic        tx_ack_i = 1'b0;
   logic        pause_request_en_i;
   pause_time_t pause_time_i;
   fifo_space_t pause_thresh_i;
   f19_word_t   rx_f19_data_o;
   logic        rx_f19_valid_o;
   logic [15:0] rx_dropped_o;
   logic        tx_f19_ready_o;
   byte_t       tx_data_o;
   logic        tx_valid_o;
   logic        tx_error_o;
   logic        pause_req_o;
   pause_time_t pause_time_req_o;

   // Expected receive words and transmit bytes, bit 8 marks the last byte
   f19_word_t   rx_exp_q[$];
   logic [8:0]  tx_exp_q[$];

   logic        rx_hold = 1'b0;
   logic        fc_on = 1'b0;
   logic        underrun_ok = 1'b0;
   logic        paused_exp = 1'b0;
   logic        acked_q = 1'b0;
   int          ack_wait = 0;
   int          pause_cnt = 0;
   int          underrun_cnt = 0;

   gemac_client_bridge dut_i (.*);

   always #4 clk125 = ~clk125;

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         stop_on_error("value mismatch");
      end
   endtask

   // Pack the frame into words as it is sent
   task automatic send_rx_frame(input int len, input bit bad, input bit keep);
      byte_t     b;
      f19_word_t w;
      int        err_at;
      w = '0;
      err_at = int'($urandom % 32'(len));
      for (int i = 0; i < len; i++) begin
         @(posedge clk125);
         b = byte_t'($urandom);
         rx_data_i  <= b;
         rx_valid_i <= 1'b1;
         rx_error_i <= bad && (i == err_at);
         if (i % 2 == 0) begin
            w = '0;
            w[15:8] = b;
            w[F19_SOF_BIT] = (i == 0);
         end else begin
            w[7:0] = b;
         end
         if (keep && (i % 2 == 1 || i == len - 1)) begin
            w[F19_EOF_BIT]  = (i == len - 1);
            w[F19_HALF_BIT] = (i % 2 == 0);
            rx_exp_q.push_back(w);
         end
      end
      @(posedge clk125);
      rx_valid_i <= 1'b0;
      rx_error_i <= 1'b0;
      repeat ($urandom % 4) @(posedge clk125);
   endtask

   // A nonzero cut drops valid for a while before that word
   task automatic send_tx_frame(input int len, input int cut);
      f19_word_t words[$];
      byte_t     b0;
      byte_t     b1;
      int        nw;
      int        tmo;
      nw = (len + 1) / 2;
      // Whole frame is expected before its first word goes out
      for (int i = 0; i < nw; i++) begin
         b0 = byte_t'($urandom);
         b1 = byte_t'($urandom);
         words.push_back({(i == nw - 1) && (len % 2 == 1), i == nw - 1, i == 0, b0, b1});
         tx_exp_q.push_back({2 * i + 1 == len, b0});
         if (2 * i + 1 < len) begin
            tx_exp_q.push_back({2 * i + 2 == len, b1});
         end
      end
      @(posedge clk125);
      for (int i = 0; i < nw; i++) begin
         if (cut > 0 && i == cut) begin
            tx_f19_valid_i <= 1'b0;
            repeat (8) @(posedge clk125);
         end
         tx_f19_data_i  <= words[i];
         tx_f19_valid_i <= 1'b1;
         tmo = 0;
         do begin
            @(posedge clk125);
            tmo++;
            if (tmo > 1000) stop_on_error("timeout waiting for tx_f19_ready_o");
         end while (!tx_f19_ready_o);
      end
      tx_f19_valid_i <= 1'b0;
   endtask

   task automatic wait_queues_empty(input string what);
      int tmo;
      tmo = 0;
      while (rx_exp_q.size() != 0 || tx_exp_q.size() != 0) begin
         @(posedge clk125);
         tmo++;
         if (tmo > 5000) stop_on_error({"timeout waiting for ", what});
      end
   endtask

   always @(posedge clk125) begin
      rx_f19_ready_i <= rx_hold ? 1'b0 : (($urandom % 4) != 0);
   end

   always @(posedge clk125) begin : rx_monitor
      f19_word_t got;
      if (!reset_i && rx_f19_valid_o && rx_f19_ready_i) begin
         if (rx_exp_q.size() == 0) begin
            stop_on_error("receive word arrived with no frame expected");
         end else begin
            got = rx_f19_data_o;
            // Second byte of a half word is not valid
            if (rx_exp_q[0][F19_HALF_BIT]) got[7:0] = 8'h00;
            check_value("rx_f19_data_o", 32'(got), 32'(rx_exp_q[0]));
            void'(rx_exp_q.pop_front());
         end
      end
   end

   always @(posedge clk125) begin : pause_monitor
      if (!reset_i && pause_req_o) begin
         assert (fc_on) else stop_on_error("pause request with flow control disabled");
         check_value("pause_time_req_o", 32'(pause_time_req_o),
                     paused_exp ? 32'h0 : 32'(pause_time_i));
         paused_exp <= !paused_exp;
         pause_cnt  <= pause_cnt + 1;
      end
   end

   // MAC model: acks after a random delay, then takes one byte per cycle
   always @(posedge clk125) begin : tx_monitor
      logic [8:0] head;
      tx_ack_i <= 1'b0;
      if (!reset_i) begin
         if (tx_error_o) begin
            assert (acked_q && underrun_ok) else stop_on_error("unexpected tx_error_o pulse");
            head = 9'h0;
            while (!head[8] && tx_exp_q.size() != 0) head = tx_exp_q.pop_front();
            underrun_cnt <= underrun_cnt + 1;
            acked_q      <= 1'b0;
         end else if (tx_valid_o && (tx_ack_i || acked_q)) begin
            if (tx_exp_q.size() == 0) begin
               stop_on_error("transmit byte sent with no frame expected");
            end else begin
               head = tx_exp_q.pop_front();
               check_value("tx_data_o", 32'(tx_data_o), 32'(head[7:0]));
               acked_q <= !head[8];
            end
         end else if (acked_q) begin
            stop_on_error("tx_valid_o fell in mid-frame without tx_error_o");
         end else if (tx_valid_o) begin
            if (ack_wait == 0) begin
               tx_ack_i <= 1'b1;
               ack_wait <= int'($urandom % 6);
            end else begin
               ack_wait <= ack_wait - 1;
            end
         end
      end
   end

   initial begin
      int tmo;
      void'($urandom(32'h5983));
      reset_i            = 1'b1;
      rx_data_i          = '0;
      rx_valid_i         = 1'b0;
      rx_error_i         = 1'b0;
      tx_f19_data_i      = '0;
      tx_f19_valid_i     = 1'b0;
      pause_request_en_i = 1'b0;
      pause_time_i       = 16'h0100;
      pause_thresh_i     = 16'd16;
      repeat (3) @(posedge clk125);
      reset_i <= 1'b0;
      check_value("rx_f19_valid_o", 32'(rx_f19_valid_o), 32'h0);
      check_value("tx_valid_o", 32'(tx_valid_o), 32'h0);
      check_value("tx_error_o", 32'(tx_error_o), 32'h0);
      check_value("pause_req_o", 32'(pause_req_o), 32'h0);
      check_value("tx_f19_ready_o", 32'(tx_f19_ready_o), 32'h0);
      check_value("rx_dropped_o", 32'(rx_dropped_o), 32'h0);

      // Random good frames around one bad frame
      for (int f = 0; f < 12; f++) begin
         send_rx_frame(1 + int'($urandom % 60), f == 5, f != 5);
      end
      wait_queues_empty("receive words");
      check_value("rx_dropped_o", 32'(rx_dropped_o), 32'h1);

      // Fill with the reader stalled, the fourth frame cannot fit
      rx_hold            <= 1'b1;
      send_rx_frame(40, 1'b0, 1'b1);
      send_rx_frame(40, 1'b0, 1'b1);
      send_rx_frame(40, 1'b0, 1'b1);
      // Space is already low here with flow control still off
      fc_on              <= 1'b1;
      pause_request_en_i <= 1'b1;
      send_rx_frame(40, 1'b0, 1'b0);
      send_rx_frame(6, 1'b0, 1'b1);
      repeat (20) @(posedge clk125);
      check_value("pause request count", 32'(pause_cnt), 32'h1);
      rx_hold <= 1'b0;
      wait_queues_empty("receive words after stall");
      tmo = 0;
      while (pause_cnt < 2) begin
         @(posedge clk125);
         tmo++;
         if (tmo > 1000) stop_on_error("timeout waiting for the resume request");
      end
      check_value("rx_dropped_o", 32'(rx_dropped_o), 32'h2);
      pause_request_en_i <= 1'b0;
      @(posedge clk125);
      fc_on <= 1'b0;

      for (int f = 0; f < 8; f++) begin
         send_tx_frame(1 + int'($urandom % 30), 0);
      end
      wait_queues_empty("transmit bytes");

      underrun_ok <= 1'b1;
      send_tx_frame(10, 2);
      send_tx_frame(7, 0);
      wait_queues_empty("transmit bytes after underrun");
      check_value("underrun count", 32'(underrun_cnt), 32'h1);

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire
